// File: run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module rv_core_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/Vrv_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: test/rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props (
  input logic              clk,
  input logic              reset,
  input logic              mem_valid,
  input logic              mem_ready,
  input rv_isa_pkg::word_t mem_addr,
  input logic              mem_write,
  input rv_isa_pkg::word_t mem_wdata,
  input logic              halted
);

  // request held until the memory takes it
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_write))
    else $error("request dropped or changed while mem_ready was low");

  a_wdata_stable: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready && mem_write |=> $stable(mem_wdata))
    else $error("store data changed while mem_ready was low");

  a_halt_idle: assert property (@(posedge clk) disable iff (reset)
    halted |-> !mem_valid)
    else $error("memory request raised while halted");

  a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted)
    else $error("halted dropped without reset");

  a_reset_quiet: assert property (@(posedge clk) reset |=> !mem_valid && !halted)
    else $error("mem_valid or halted high right after reset");

endmodule

bind rv_core rv_core_props i_props (
  .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_ready(mem_ready),
  .mem_addr(mem_addr), .mem_write(mem_write), .mem_wdata(mem_wdata), .halted(halted)
);

// File: test/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core_tb;

  localparam int INIT_N     = 31;   // one addi per register x1..x31
  localparam int PROG_N     = 180;
  localparam int PAD_N      = 10;   // landing room for the last forward jumps
  localparam int STORE_IDX  = INIT_N + PROG_N + PAD_N;
  localparam int MAX_CYCLES = 20000;
  localparam int HALT_HOLD  = 20;

  logic clk;
  logic reset;
  logic mem_valid;
  logic mem_ready;
  logic mem_write;
  logic halted;
  rv_isa_pkg::word_t mem_addr;
  rv_isa_pkg::word_t mem_wdata;
  rv_isa_pkg::word_t mem_rdata;

  rv_isa_pkg::word_t ram [0:1023];   // memory behind the DUT port
  rv_isa_pkg::word_t mmem [0:1023];  // model copy
  rv_isa_pkg::word_t mregs [0:31];
  rv_isa_pkg::word_t m_pc;
  rv_isa_pkg::word_t exp_addr;
  rv_isa_pkg::word_t exp_wdata;
  rv_isa_pkg::word_t lfsr_q;
  logic exp_data;    // next transfer is a load/store
  logic exp_store;
  logic m_halted;
  logic x0_store;
  int errors;
  int retired;
  int transfers;

  rv_core i_dut (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_addr(mem_addr), .mem_write(mem_write), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata), .halted(halted)
  );

  always #10 clk = ~clk;

  function automatic rv_isa_pkg::word_t lfsr_next(input rv_isa_pkg::word_t s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic rv_isa_pkg::word_t rand_bits(input int n);
    rv_isa_pkg::word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic rv_isa_pkg::reg_idx_t rand_reg();
    rv_isa_pkg::word_t r;
    r = rand_bits(5);
    return r[4:0];
  endfunction

  function automatic rv_isa_pkg::word_t enc_i(input logic [11:0] imm,
                                              input rv_isa_pkg::reg_idx_t rs1,
                                              input logic [2:0] f3,
                                              input rv_isa_pkg::reg_idx_t rd,
                                              input rv_isa_pkg::opcode_e op);
    enc_i = {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_isa_pkg::word_t enc_s(input logic [11:0] imm,
                                              input rv_isa_pkg::reg_idx_t rs2,
                                              input rv_isa_pkg::reg_idx_t rs1);
    enc_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::op_store};  // sw
  endfunction

  function automatic rv_isa_pkg::word_t enc_b(input logic [12:0] off,
                                              input rv_isa_pkg::reg_idx_t rs2,
                                              input rv_isa_pkg::reg_idx_t rs1,
                                              input logic [2:0] f3);
    enc_b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::op_branch};
  endfunction

  function automatic rv_isa_pkg::word_t enc_j(input logic [20:0] off,
                                              input rv_isa_pkg::reg_idx_t rd);
    enc_j = {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::op_jal};
  endfunction

  // one random instruction for word idx, jumps only go forward by 1..8 words
  function automatic rv_isa_pkg::word_t gen_instr(input int idx);
    rv_isa_pkg::word_t kind;
    rv_isa_pkg::word_t r;
    rv_isa_pkg::word_t t;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [3:0] step;
    kind = rand_bits(4);
    rd = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    r = rand_bits(3);
    f3 = r[2:0];
    r = rand_bits(3);
    step = {1'b0, r[2:0]} + 4'd1;
    r = rand_bits(1);
    f7 = r[0] ? 7'b010_0000 : 7'b000_0000;
    if (kind < 4) begin
      if (f3 != 3'b000 && f3 != 3'b101) begin
        f7 = '0;  // only sub and sra have an alternate form
      end
      gen_instr = {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_reg};
    end else if (kind < 7) begin
      r = rand_bits(12);
      if (f3 == 3'b001) begin
        r[11:5] = '0;  // slli
      end else if (f3 == 3'b101) begin
        r[11:5] = f7;  // srli or srai
      end
      gen_instr = enc_i(r[11:0], rs1, f3, rd, rv_isa_pkg::op_imm);
    end else if (kind == 7) begin
      r = rand_bits(20);
      gen_instr = {r[19:0], rd, rv_isa_pkg::op_lui};
    end else if (kind == 8) begin
      r = rand_bits(20);
      gen_instr = {r[19:0], rd, rv_isa_pkg::op_auipc};
    end else if (kind == 9) begin
      if (f3[2:1] == 2'b01) begin
        f3[2:1] = 2'b00;  // 010 and 011 are not branches
      end
      gen_instr = enc_b({7'd0, step, 2'b00}, rs2, rs1, f3);
    end else if (kind == 10) begin
      gen_instr = enc_j({15'd0, step, 2'b00}, rd);
    end else if (kind == 11) begin
      // absolute target from x0, odd half the time
      t = (rv_isa_pkg::word_t'(idx) + {28'd0, step}) << 2;
      gen_instr = enc_i({t[11:1], f7[5]}, 5'd0, 3'b000, rd, rv_isa_pkg::op_jalr);
    end else if (kind == 12) begin
      r = rand_bits(10);
      gen_instr = enc_i({2'b01, r[9:0]}, 5'd0, 3'b010, rd, rv_isa_pkg::op_load);
    end else if (kind < 15) begin
      r = rand_bits(10);
      gen_instr = enc_s({2'b01, r[9:0]}, rs2, 5'd0);  // data words 256..511
    end else begin
      r = rand_bits(32);
      case (r[6:0])
        rv_isa_pkg::op_reg, rv_isa_pkg::op_imm, rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc,
        rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr, rv_isa_pkg::op_branch, rv_isa_pkg::op_load,
        rv_isa_pkg::op_store, rv_isa_pkg::op_system: begin
          r[6:0] = 7'b000_1111;  // fence, treated as unknown
        end
        default: begin
        end
      endcase
      gen_instr = r;
    end
  endfunction

  task automatic load_program();
    rv_isa_pkg::word_t r;
    logic [9:0] a10;
    lfsr_q = 32'd90;
    for (int i = 0; i < 1024; i++) begin
      a10 = i[9:0];
      ram[i] = {a10, 6'h2a, ~a10, 6'h15};
    end
    for (int i = 1; i <= INIT_N; i++) begin
      r = rand_bits(12);
      ram[i-1] = enc_i(r[11:0], 5'd0, 3'b000, rv_isa_pkg::reg_idx_t'(i), rv_isa_pkg::op_imm);
    end
    for (int i = INIT_N; i < INIT_N + PROG_N; i++) begin
      ram[i] = gen_instr(i);
    end
    for (int i = INIT_N + PROG_N; i < STORE_IDX; i++) begin
      ram[i] = 32'h0000_0013;  // nop
    end
    ram[STORE_IDX] = enc_s(12'h7f0, 5'd0, 5'd0);  // sw x0
    ram[STORE_IDX+1] = 32'h0010_0073;              // ebreak
    for (int i = 0; i < 1024; i++) begin
      mmem[i] = ram[i];
    end
  endtask

  function automatic rv_isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic sub_en,
                                                input logic sra_en, input rv_isa_pkg::word_t a,
                                                input rv_isa_pkg::word_t b);
    case (f3)
      3'b000:  alu_ref = sub_en ? a - b : a + b;
      3'b001:  alu_ref = a << b[4:0];
      3'b010:  alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  alu_ref = (a < b) ? 32'd1 : 32'd0;
      3'b100:  alu_ref = a ^ b;
      3'b101:  alu_ref = sra_en ? rv_isa_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  // executes the instruction at m_pc in full
  task automatic model_step();
    rv_isa_pkg::word_t w;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t res;
    rv_isa_pkg::word_t nxt;
    rv_isa_pkg::word_t imm_i;
    rv_isa_pkg::word_t imm_s;
    rv_isa_pkg::word_t imm_b;
    rv_isa_pkg::word_t imm_u;
    rv_isa_pkg::word_t imm_j;
    logic [2:0] f3;
    logic wr;
    logic taken;
    w = mmem[m_pc[11:2]];
    f3 = w[14:12];
    a = mregs[w[19:15]];
    b = mregs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'd0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    nxt = m_pc + 32'd4;
    res = '0;
    wr = 1'b0;
    taken = 1'b0;
    x0_store = (int'(m_pc[11:2]) == STORE_IDX);
    case (w[6:0])
      rv_isa_pkg::op_reg: begin
        res = alu_ref(f3, w[30], w[30], a, b);
        wr = 1'b1;
      end
      rv_isa_pkg::op_imm: begin
        res = alu_ref(f3, 1'b0, w[30], a, imm_i);
        wr = 1'b1;
      end
      rv_isa_pkg::op_lui: begin
        res = imm_u;
        wr = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        res = m_pc + imm_u;
        wr = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        res = m_pc + 32'd4;
        nxt = m_pc + imm_j;
        wr = 1'b1;
      end
      rv_isa_pkg::op_jalr: begin
        res = m_pc + 32'd4;
        nxt = (a + imm_i) & ~32'd1;
        wr = 1'b1;
      end
      rv_isa_pkg::op_branch: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          3'b111:  taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          nxt = m_pc + imm_b;
        end
      end
      rv_isa_pkg::op_load: begin
        exp_data = 1'b1;
        exp_store = 1'b0;
        exp_addr = a + imm_i;
        res = mmem[exp_addr[11:2]];
        wr = 1'b1;
      end
      rv_isa_pkg::op_store: begin
        exp_data = 1'b1;
        exp_store = 1'b1;
        exp_addr = a + imm_s;
        exp_wdata = b;
        mmem[exp_addr[11:2]] = b;
      end
      rv_isa_pkg::op_system: begin
        if (w == 32'h0010_0073) begin
          m_halted = 1'b1;
          nxt = m_pc;
        end
      end
      default: begin
      end
    endcase
    if (wr && w[11:7] != 5'd0) begin
      mregs[w[11:7]] = res;
    end
    m_pc = nxt;
    retired++;
  endtask

  task automatic check_word(input string name, input rv_isa_pkg::word_t exp,
                            input rv_isa_pkg::word_t act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // memory responder and transfer monitor, ready only after a cycle of valid
  always @(posedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
    end else if (mem_valid && mem_ready) begin
      transfers++;
      if (m_halted) begin
        errors++;
        $display("memory transfer seen after the model reached ebreak");
      end else if (!exp_data) begin
        check_word("fetch address", m_pc, mem_addr);
        check_bit("fetch write", 1'b0, mem_write);
        model_step();
      end else begin
        check_word("data address", exp_addr, mem_addr);
        check_bit("data write", exp_store, mem_write);
        if (exp_store) begin
          check_word("store data", exp_wdata, mem_wdata);
        end
        if (x0_store) begin
          check_word("x0 store data", 32'h0, mem_wdata);
        end
        exp_data = 1'b0;
      end
      if (mem_write) begin
        ram[mem_addr[11:2]] <= mem_wdata;
      end
      mem_ready <= 1'b0;
    end else if (mem_valid) begin
      if (rand_bits(2) != 32'd0) begin
        mem_ready <= 1'b1;
        mem_rdata <= ram[mem_addr[11:2]];
      end
    end
  end

  initial begin
    int cycles;
    clk = 1'b0;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    errors = 0;
    retired = 0;
    transfers = 0;
    exp_data = 1'b0;
    exp_store = 1'b0;
    exp_addr = '0;
    exp_wdata = '0;
    m_halted = 1'b0;
    x0_store = 1'b0;
    m_pc = `RV_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    load_program();

    repeat (2) @(posedge clk);
    check_bit("valid in reset", 1'b0, mem_valid);
    check_bit("halted in reset", 1'b0, halted);
    reset <= 1'b0;
    @(posedge clk);
    check_bit("valid after reset", 1'b0, mem_valid);
    check_bit("halted after reset", 1'b0, halted);

    cycles = 0;
    while (!halted && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("timeout: core did not halt within %0d cycles", MAX_CYCLES);
    end else begin
      if (!m_halted) begin
        errors++;
        $display("core halted before the model reached ebreak");
      end
      repeat (HALT_HOLD) begin
        @(posedge clk);
        check_bit("halted held", 1'b1, halted);
        check_bit("valid after halt", 1'b0, mem_valid);
      end
    end

    $display("errors: %0d, instructions: %0d, transfers: %0d, cycles: %0d",
             errors, retired, transfers, cycles);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/rv_alu.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_alu (
  input  rv_core_pkg::alu_op_e alu_op,
  input  rv_core_pkg::src_a_e  src_a,
  input  rv_core_pkg::src_b_e  src_b,
  input  rv_isa_pkg::word_t    rs1_data,
  input  rv_isa_pkg::word_t    rs2_data,
  input  rv_isa_pkg::word_t    pc,
  input  rv_isa_pkg::word_t    imm,
  output rv_isa_pkg::word_t    result,
  output logic                 cond
);

  rv_isa_pkg::word_t op_a;
  rv_isa_pkg::word_t op_b;
  rv_isa_pkg::word_t diff;
  logic [4:0] shamt;
  logic carry;   // no borrow, op_a >= op_b unsigned
  logic zero;
  logic sign;
  logic ovf;

  always_comb begin
    case (src_a)
      rv_core_pkg::src_a_pc:  op_a = pc;
      rv_core_pkg::src_a_rs1: op_a = rs1_data;
      default:                op_a = '0;  // lui
    endcase
  end

  assign op_b = (src_b == rv_core_pkg::src_b_imm) ? imm : rs2_data;
  assign shamt = op_b[4:0];

  // one subtractor for sub and every compare
  assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + {{`RV_XLEN{1'b0}}, 1'b1};
  assign zero = (diff == '0);
  assign sign = diff[`RV_XLEN-1];
  assign ovf  = (op_a[`RV_XLEN-1] != op_b[`RV_XLEN-1]) && (sign != op_a[`RV_XLEN-1]);

  always_comb begin
    case (alu_op)
      rv_core_pkg::eq:  cond = zero;
      rv_core_pkg::ne:  cond = !zero;
      rv_core_pkg::lt:  cond = sign ^ ovf;
      rv_core_pkg::ge:  cond = !(sign ^ ovf);
      rv_core_pkg::ltu: cond = !carry;
      rv_core_pkg::geu: cond = carry;
      default:          cond = 1'b0;  // not a compare
    endcase
  end

  always_comb begin
    case (alu_op)
      rv_core_pkg::add:    result = op_a + op_b;
      rv_core_pkg::sub:    result = diff;
      rv_core_pkg::and_op: result = op_a & op_b;
      rv_core_pkg::or_op:  result = op_a | op_b;
      rv_core_pkg::xor_op: result = op_a ^ op_b;
      rv_core_pkg::sll:    result = op_a << shamt;
      rv_core_pkg::srl:    result = op_a >> shamt;
      rv_core_pkg::sra:    result = $signed(op_a) >>> shamt;
      default:             result = {{(`RV_XLEN-1){1'b0}}, cond};  // slt, sltu
    endcase
  end

endmodule

// File: verilog/rv_control.sv
`timescale 1ns/1ps

module rv_control (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_isa_pkg::word_t     instr,
  input  logic                  mem_ready,
  input  logic                  cond,
  output logic                  mem_valid,
  output logic                  mem_write,
  output logic                  ir_load,
  output logic                  pc_load,
  output rv_core_pkg::pc_sel_e  pc_sel,
  output logic                  rf_wen,
  output rv_core_pkg::wb_sel_e  wb_sel,
  output rv_core_pkg::alu_op_e  alu_op,
  output rv_core_pkg::src_a_e   src_a,
  output rv_core_pkg::src_b_e   src_b,
  output rv_core_pkg::imm_fmt_e imm_fmt,
  output logic                  data_phase,
  output logic                  halted
);

  rv_core_pkg::core_state_e state;
  rv_core_pkg::core_state_e state_next;
  rv_isa_pkg::opcode_e      opcode;
  rv_isa_pkg::f3_alu_e      f3_alu;
  rv_isa_pkg::f3_branch_e   f3_br;
  logic valid_q;
  logic valid_next;
  logic write_q;
  logic write_next;
  logic dec_wen;    // instruction writes rd
  logic is_load;
  logic is_store;
  logic is_ebreak;
  logic xfer;

  // funct7 bit 5 picks sub/sra, sub only exists for op_reg
  function automatic rv_core_pkg::alu_op_e alu_decode(input rv_isa_pkg::f3_alu_e f3,
                                                      input logic alt,
                                                      input logic is_reg);
    case (f3)
      rv_isa_pkg::f3_add:  alu_decode = (alt && is_reg) ? rv_core_pkg::sub : rv_core_pkg::add;
      rv_isa_pkg::f3_sll:  alu_decode = rv_core_pkg::sll;
      rv_isa_pkg::f3_slt:  alu_decode = rv_core_pkg::lt;
      rv_isa_pkg::f3_sltu: alu_decode = rv_core_pkg::ltu;
      rv_isa_pkg::f3_xor:  alu_decode = rv_core_pkg::xor_op;
      rv_isa_pkg::f3_sr:   alu_decode = alt ? rv_core_pkg::sra : rv_core_pkg::srl;
      rv_isa_pkg::f3_or:   alu_decode = rv_core_pkg::or_op;
      default:             alu_decode = rv_core_pkg::and_op;
    endcase
  endfunction

  assign opcode    = rv_isa_pkg::opcode_e'(instr[6:0]);
  assign f3_alu    = rv_isa_pkg::f3_alu_e'(instr[14:12]);
  assign f3_br     = rv_isa_pkg::f3_branch_e'(instr[14:12]);
  assign is_load   = (opcode == rv_isa_pkg::op_load);
  assign is_store  = (opcode == rv_isa_pkg::op_store);
  assign is_ebreak = (instr == 32'h0010_0073);  // other system encodings are no-ops
  assign xfer      = valid_q && mem_ready;

  always_comb begin
    dec_wen = 1'b0;
    wb_sel  = rv_core_pkg::wb_alu;
    alu_op  = rv_core_pkg::add;
    src_a   = rv_core_pkg::src_a_rs1;
    src_b   = rv_core_pkg::src_b_imm;
    imm_fmt = rv_core_pkg::imm_i;
    pc_sel  = rv_core_pkg::pc_sel_seq;
    case (opcode)
      rv_isa_pkg::op_reg: begin
        dec_wen = 1'b1;
        src_b   = rv_core_pkg::src_b_rs2;
        alu_op  = alu_decode(f3_alu, instr[30], 1'b1);
      end
      rv_isa_pkg::op_imm: begin
        dec_wen = 1'b1;
        alu_op  = alu_decode(f3_alu, instr[30], 1'b0);
      end
      rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc: begin
        dec_wen = 1'b1;
        imm_fmt = rv_core_pkg::imm_u;
        src_a   = (opcode == rv_isa_pkg::op_lui) ? rv_core_pkg::src_a_zero : rv_core_pkg::src_a_pc;
      end
      rv_isa_pkg::op_jal: begin
        dec_wen = 1'b1;
        wb_sel  = rv_core_pkg::wb_pc4;
        imm_fmt = rv_core_pkg::imm_j;
        pc_sel  = rv_core_pkg::pc_sel_imm;
      end
      rv_isa_pkg::op_jalr: begin
        dec_wen = 1'b1;
        wb_sel  = rv_core_pkg::wb_pc4;
        pc_sel  = rv_core_pkg::pc_sel_alu;  // rs1 + imm
      end
      rv_isa_pkg::op_branch: begin
        src_b   = rv_core_pkg::src_b_rs2;
        imm_fmt = rv_core_pkg::imm_b;
        case (f3_br)
          rv_isa_pkg::f3_beq:  alu_op = rv_core_pkg::eq;
          rv_isa_pkg::f3_bne:  alu_op = rv_core_pkg::ne;
          rv_isa_pkg::f3_blt:  alu_op = rv_core_pkg::lt;
          rv_isa_pkg::f3_bge:  alu_op = rv_core_pkg::ge;
          rv_isa_pkg::f3_bltu: alu_op = rv_core_pkg::ltu;
          rv_isa_pkg::f3_bgeu: alu_op = rv_core_pkg::geu;
          default:             alu_op = rv_core_pkg::add;  // cond stays 0, falls through
        endcase
        pc_sel = cond ? rv_core_pkg::pc_sel_imm : rv_core_pkg::pc_sel_seq;
      end
      rv_isa_pkg::op_load: begin
        wb_sel = rv_core_pkg::wb_mem;
      end
      rv_isa_pkg::op_store: begin
        imm_fmt = rv_core_pkg::imm_s;
      end
      default: begin
      end
    endcase
  end

  // mem_valid is registered, so the next request is raised together with the pc update
  always_comb begin
    state_next = state;
    valid_next = valid_q;
    write_next = write_q;
    ir_load    = 1'b0;
    pc_load    = 1'b0;
    rf_wen     = 1'b0;
    case (state)
      rv_core_pkg::st_fetch: begin
        if (!valid_q) begin
          valid_next = 1'b1;  // only right after reset
        end else if (xfer) begin
          ir_load    = 1'b1;
          valid_next = 1'b0;
          state_next = rv_core_pkg::st_exec;
        end
      end
      rv_core_pkg::st_exec: begin
        if (is_load || is_store) begin
          valid_next = 1'b1;
          write_next = is_store;
          state_next = rv_core_pkg::st_mem;
        end else if (is_ebreak) begin
          state_next = rv_core_pkg::st_halt;
        end else begin
          rf_wen     = dec_wen;
          pc_load    = 1'b1;
          valid_next = 1'b1;
          state_next = rv_core_pkg::st_fetch;
        end
      end
      rv_core_pkg::st_mem: begin
        if (xfer) begin
          rf_wen     = is_load;
          pc_load    = 1'b1;
          write_next = 1'b0;  // valid stays up for the next fetch
          state_next = rv_core_pkg::st_fetch;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= rv_core_pkg::st_fetch;
      valid_q <= 1'b0;
      write_q <= 1'b0;
    end else begin
      state   <= state_next;
      valid_q <= valid_next;
      write_q <= write_next;
    end
  end

  assign mem_valid  = valid_q;
  assign mem_write  = write_q;
  assign data_phase = (state == rv_core_pkg::st_mem);
  assign halted     = (state == rv_core_pkg::st_halt);

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic              clk,
  input  logic              reset,
  output logic              mem_valid,
  input  logic              mem_ready,
  output rv_isa_pkg::word_t mem_addr,
  output logic              mem_write,
  output rv_isa_pkg::word_t mem_wdata,
  input  rv_isa_pkg::word_t mem_rdata,
  output logic              halted
);

  rv_isa_pkg::word_t     instr;
  rv_isa_pkg::word_t     pc;
  rv_isa_pkg::word_t     pc_plus4;
  rv_isa_pkg::word_t     imm;
  rv_isa_pkg::word_t     alu_result;
  rv_isa_pkg::word_t     rs1_data;
  rv_isa_pkg::word_t     rs2_data;
  logic                  cond;
  logic                  ir_load;
  logic                  pc_load;
  logic                  rf_wen;
  logic                  data_phase;
  rv_core_pkg::pc_sel_e  pc_sel;
  rv_core_pkg::wb_sel_e  wb_sel;
  rv_core_pkg::alu_op_e  alu_op;
  rv_core_pkg::src_a_e   src_a;
  rv_core_pkg::src_b_e   src_b;
  rv_core_pkg::imm_fmt_e imm_fmt;

  rv_control i_control (
    .clk(clk), .reset(reset), .instr(instr), .mem_ready(mem_ready), .cond(cond),
    .mem_valid(mem_valid), .mem_write(mem_write), .ir_load(ir_load), .pc_load(pc_load),
    .pc_sel(pc_sel), .rf_wen(rf_wen), .wb_sel(wb_sel), .alu_op(alu_op), .src_a(src_a),
    .src_b(src_b), .imm_fmt(imm_fmt), .data_phase(data_phase), .halted(halted)
  );

  rv_pc_bus i_pc_bus (
    .clk(clk), .reset(reset), .pc_load(pc_load), .pc_sel(pc_sel), .ir_load(ir_load),
    .data_phase(data_phase), .imm(imm), .alu_result(alu_result), .rs2_data(rs2_data),
    .mem_rdata(mem_rdata), .pc(pc), .pc_plus4(pc_plus4), .instr(instr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

  // register fields straight from the instruction register
  rv_regfile i_regfile (
    .clk(clk), .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]), .rf_wen(rf_wen),
    .wb_sel(wb_sel), .alu_result(alu_result), .mem_rdata(mem_rdata), .pc_plus4(pc_plus4),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_imm_gen i_imm_gen (.instr(instr), .imm_fmt(imm_fmt), .imm(imm));

  rv_alu i_alu (
    .alu_op(alu_op), .src_a(src_a), .src_b(src_b), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .pc(pc), .imm(imm), .result(alu_result), .cond(cond)
  );

endmodule

// File: verilog/rv_core_pkg.sv
package rv_core_pkg;

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_mem,
    st_halt
  } core_state_e;

  // eq .. geu only drive cond, result gets cond zero-extended
  typedef enum logic [3:0] {
    add, sub, and_op, or_op, xor_op, sll, srl, sra,
    eq, ne, lt, ge, ltu, geu
  } alu_op_e;

  typedef enum logic [1:0] {src_a_rs1, src_a_pc, src_a_zero} src_a_e;

  typedef enum logic {src_b_rs2, src_b_imm} src_b_e;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_fmt_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;

  // pc_sel_alu is used by jalr, bit 0 gets cleared
  typedef enum logic [1:0] {pc_sel_seq, pc_sel_imm, pc_sel_alu} pc_sel_e;

endpackage

// File: verilog/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen (
  input  rv_isa_pkg::word_t     instr,
  input  rv_core_pkg::imm_fmt_e imm_fmt,
  output rv_isa_pkg::word_t     imm
);

  logic sign;

  assign sign = instr[31];  // every format takes its sign from bit 31

  always_comb begin
    case (imm_fmt)
      rv_core_pkg::imm_i: begin
        imm = {{20{sign}}, instr[31:20]};
      end
      rv_core_pkg::imm_s: begin
        imm = {{20{sign}}, instr[31:25], instr[11:7]};
      end
      rv_core_pkg::imm_b: begin
        // branch offset, bit 0 always zero
        imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      rv_core_pkg::imm_u: begin
        imm = {instr[31:12], 12'h000};
      end
      rv_core_pkg::imm_j: begin
        imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// File: verilog/rv_isa_pkg.sv
`include "rv_macros.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_AW-1:0] reg_idx_t;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    op_reg    = 7'b011_0011,
    op_imm    = 7'b001_0011,
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_branch = 7'b110_0011,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_system = 7'b111_0011
  } opcode_e;

  // funct3 of op_reg / op_imm
  typedef enum logic [2:0] {
    f3_add  = 3'b000, // add, sub, addi
    f3_sll  = 3'b001,
    f3_slt  = 3'b010,
    f3_sltu = 3'b011,
    f3_xor  = 3'b100,
    f3_sr   = 3'b101, // srl and sra, told apart by instr[30]
    f3_or   = 3'b110,
    f3_and  = 3'b111
  } f3_alu_e;

  // funct3 of op_branch, 010 and 011 are unused
  typedef enum logic [2:0] {
    f3_beq  = 3'b000,
    f3_bne  = 3'b001,
    f3_blt  = 3'b100,
    f3_bge  = 3'b101,
    f3_bltu = 3'b110,
    f3_bgeu = 3'b111
  } f3_branch_e;

endpackage

// File: verilog/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and address width
`define RV_XLEN 32

// first fetch address out of reset
`define RV_RESET_PC 32'h8000_0000

// architectural register file
`define RV_REG_COUNT 32
`define RV_REG_AW 5

`endif

// File: verilog/rv_pc_bus.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_pc_bus (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pc_load,
  input  rv_core_pkg::pc_sel_e pc_sel,
  input  logic                 ir_load,
  input  logic                 data_phase,
  input  rv_isa_pkg::word_t    imm,
  input  rv_isa_pkg::word_t    alu_result,
  input  rv_isa_pkg::word_t    rs2_data,
  input  rv_isa_pkg::word_t    mem_rdata,
  output rv_isa_pkg::word_t    pc,
  output rv_isa_pkg::word_t    pc_plus4,
  output rv_isa_pkg::word_t    instr,
  output rv_isa_pkg::word_t    mem_addr,
  output rv_isa_pkg::word_t    mem_wdata
);

  rv_isa_pkg::word_t pc_q;
  rv_isa_pkg::word_t ir_q;
  rv_isa_pkg::word_t pc_imm;
  rv_isa_pkg::word_t pc_next;

  assign pc_plus4 = pc_q + 32'd4;
  assign pc_imm   = pc_q + imm;  // jal and taken branches

  always_comb begin
    case (pc_sel)
      rv_core_pkg::pc_sel_imm: pc_next = pc_imm;
      rv_core_pkg::pc_sel_alu: pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
      default:                 pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= `RV_RESET_PC;
    end else if (pc_load) begin
      pc_q <= pc_next;
    end
  end

  // captured on the fetch transfer
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir_q <= mem_rdata;
    end
  end

  assign pc        = pc_q;
  assign instr     = ir_q;
  assign mem_addr  = data_phase ? alu_result : pc_q;  // load/store address in st_mem
  assign mem_wdata = rs2_data;

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_regfile (
  input  logic                 clk,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::reg_idx_t rd,
  input  logic                 rf_wen,
  input  rv_core_pkg::wb_sel_e wb_sel,
  input  rv_isa_pkg::word_t    alu_result,
  input  rv_isa_pkg::word_t    mem_rdata,
  input  rv_isa_pkg::word_t    pc_plus4,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);

  rv_isa_pkg::word_t regs [0:`RV_REG_COUNT-1];
  rv_isa_pkg::word_t wb_data;

  always_comb begin
    case (wb_sel)
      rv_core_pkg::wb_mem: wb_data = mem_rdata;  // load
      rv_core_pkg::wb_pc4: wb_data = pc_plus4;   // link for jal/jalr
      default:             wb_data = alu_result;
    endcase
  end

  // x0 is never written, reads below return zero
  always_ff @(posedge clk) begin
    if (rf_wen && rd != '0) begin
      regs[rd] <= wb_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: vlog.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/rv_regfile.sv
verilog/rv_imm_gen.sv
verilog/rv_alu.sv
verilog/rv_pc_bus.sv
verilog/rv_control.sv
verilog/rv_core.sv
test/rv_core_props.sv
test/rv_core_tb.sv
